//--- common/issue_defs.svh
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Station and unit sizing
`define NUM_FU      3
`define NUM_PREG    32
`define TAG_W       5

// ROB slots seen by the rollback compare
`define NUM_ROB     16
`define ROB_W       4

`define XLEN        32

// Cycles from MUL acceptance to a valid result, at least 2
`define MUL_LATENCY 3

// Unit kind per station entry, index 0 first
`define FU_KIND_LIST '{issue_pkg::FU_ALU, issue_pkg::FU_ALU, issue_pkg::FU_MUL}

`endif

//--- common/issue_pkg.sv
`default_nettype none

`include "issue_defs.svh"

package issue_pkg;

  typedef enum logic {
    FU_ALU,
    FU_MUL
  } fu_kind_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_MUL,
    OP_LI   // Load immediate
  } func_t;

  typedef struct packed {
    logic               busy;
    func_t              func;
    logic [`ROB_W-1:0]  rob_idx;
    logic [`TAG_W-1:0]  t_idx;     // Destination tag
    logic [`TAG_W-1:0]  t1_idx;
    logic               t1_ready;
    logic [`TAG_W-1:0]  t2_idx;
    logic               t2_ready;
    logic [`XLEN-1:0]   imm;
  } rs_entry_t;

  typedef enum logic [1:0] {
    FU_IDLE,
    FU_BUSY,
    FU_DONE
  } fu_state_t;

endpackage

`default_nettype wire

//--- rs/rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module rs (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire logic                                dispatch_en,
  input  wire issue_pkg::fu_kind_t                 dispatch_kind,
  input  wire issue_pkg::func_t                    dispatch_func,
  input  wire logic [`ROB_W-1:0]                   dispatch_rob_idx,
  input  wire logic [`TAG_W-1:0]                   dispatch_t_idx,
  input  wire logic [`TAG_W-1:0]                   dispatch_t1_idx,
  input  wire logic                                dispatch_t1_ready,
  input  wire logic [`TAG_W-1:0]                   dispatch_t2_idx,
  input  wire logic                                dispatch_t2_ready,
  input  wire logic [`XLEN-1:0]                    dispatch_imm,
  input  wire logic                                rollback_en,
  input  wire logic [`ROB_W-1:0]                   rollback_idx,
  input  wire logic [`ROB_W-1:0]                   rob_tail,
  input  wire logic                                cdb_valid,
  input  wire logic [`TAG_W-1:0]                   cdb_tag,
  input  wire logic [`NUM_FU-1:0]                  fu_ready,
  output logic                                     dispatch_ok,
  output logic [`NUM_FU-1:0]                       issue_valid,
  output issue_pkg::rs_entry_t [`NUM_FU-1:0]       issue_entry
);

  localparam issue_pkg::fu_kind_t FU_KIND [`NUM_FU] = `FU_KIND_LIST;

  issue_pkg::rs_entry_t [`NUM_FU-1:0] entry;
  issue_pkg::rs_entry_t [`NUM_FU-1:0] entry_next;

  logic [`NUM_FU-1:0]             t1_rdy;     // Ready or woken this cycle
  logic [`NUM_FU-1:0]             t2_rdy;
  logic [`NUM_FU-1:0]             squash;
  logic [`NUM_FU-1:0]             fire;       // Handed to its unit at this edge
  logic [`NUM_FU-1:0]             empty;      // Free at the next edge
  logic [`NUM_FU-1:0]             slot;       // First free entry of the right kind
  logic [`ROB_W-1:0]              tail_dist;
  logic [`NUM_FU-1:0][`ROB_W-1:0] rob_dist;
  logic                           disp_t1_rdy;
  logic                           disp_t2_rdy;

  // Distances wrap modulo the ROB size
  assign tail_dist = rob_tail - rollback_idx;

  assign disp_t1_rdy = dispatch_t1_ready || (cdb_valid && dispatch_t1_idx == cdb_tag);
  assign disp_t2_rdy = dispatch_t2_ready || (cdb_valid && dispatch_t2_idx == cdb_tag);

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      t1_rdy[i]      = entry[i].t1_ready || (cdb_valid && entry[i].t1_idx == cdb_tag);
      t2_rdy[i]      = entry[i].t2_ready || (cdb_valid && entry[i].t2_idx == cdb_tag);
      rob_dist[i]    = entry[i].rob_idx - rollback_idx;
      squash[i]      = rollback_en && entry[i].busy && (rob_dist[i] <= tail_dist);
      issue_valid[i] = entry[i].busy && t1_rdy[i] && t2_rdy[i] && !squash[i];
      fire[i]        = issue_valid[i] && fu_ready[i];
      empty[i]       = !entry[i].busy || fire[i] || squash[i];

      issue_entry[i] = entry[i];
    end
  end

  // Lowest matching index wins
  always_comb begin
    slot = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (empty[i] && FU_KIND[i] == dispatch_kind && slot == '0) begin
        slot[i] = 1'b1;
      end
    end
  end

  assign dispatch_ok = |slot;

  always_comb begin
    entry_next = entry;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (dispatch_en && slot[i]) begin
        entry_next[i].busy     = 1'b1;
        entry_next[i].func     = dispatch_func;
        entry_next[i].rob_idx  = dispatch_rob_idx;
        entry_next[i].t_idx    = dispatch_t_idx;
        entry_next[i].t1_idx   = dispatch_t1_idx;
        entry_next[i].t1_ready = disp_t1_rdy;
        entry_next[i].t2_idx   = dispatch_t2_idx;
        entry_next[i].t2_ready = disp_t2_rdy;
        entry_next[i].imm      = dispatch_imm;
      end else if (empty[i]) begin
        entry_next[i] = '0;                 // Issued, squashed or idle
      end else begin
        entry_next[i].t1_ready = t1_rdy[i]; // Keep waiting, latch wakeup
        entry_next[i].t2_ready = t2_rdy[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry <= '0;
    end else begin
      entry <= entry_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/func_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module func_unit #(
  parameter issue_pkg::fu_kind_t KIND = issue_pkg::FU_ALU
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  issue_valid,
  input  wire issue_pkg::rs_entry_t  issue_entry,
  input  wire logic [`XLEN-1:0]      rd_value1,
  input  wire logic [`XLEN-1:0]      rd_value2,
  input  wire logic                  grant,
  output logic                       fu_ready,
  output logic                       done,
  output logic [`TAG_W-1:0]          result_tag,
  output logic [`XLEN-1:0]           result_value,
  output logic [`ROB_W-1:0]          result_rob_idx
);

  localparam int CNT_W = $clog2(`MUL_LATENCY);

  issue_pkg::fu_state_t state;
  logic [CNT_W-1:0]     count;       // Remaining MUL cycles
  logic [`XLEN-1:0]     op_a;
  logic [`XLEN-1:0]     op_b;
  logic [`XLEN-1:0]     alu_value;
  logic                 accept;
  logic                 mul_finish;

  assign fu_ready   = (state == issue_pkg::FU_IDLE);
  assign done       = (state == issue_pkg::FU_DONE);
  assign accept     = issue_valid && fu_ready;
  assign mul_finish = (state == issue_pkg::FU_BUSY) && (count == '0);

  always_comb begin
    case (issue_entry.func)
      issue_pkg::OP_ADD: alu_value = rd_value1 + rd_value2;
      issue_pkg::OP_SUB: alu_value = rd_value1 - rd_value2;
      issue_pkg::OP_AND: alu_value = rd_value1 & rd_value2;
      issue_pkg::OP_XOR: alu_value = rd_value1 ^ rd_value2;
      issue_pkg::OP_LI:  alu_value = issue_entry.imm;
      default:           alu_value = '0;  // MUL goes through the pipeline
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= issue_pkg::FU_IDLE;
      count <= '0;
    end else begin
      case (state)
        issue_pkg::FU_IDLE: begin
          if (accept && KIND == issue_pkg::FU_MUL) begin
            state <= issue_pkg::FU_BUSY;
            count <= CNT_W'(`MUL_LATENCY - 1);
          end else if (accept) begin
            state <= issue_pkg::FU_DONE;  // ALU result ready next cycle
          end
        end
        issue_pkg::FU_BUSY: begin
          if (count == '0) begin
            state <= issue_pkg::FU_DONE;
          end else begin
            count <= count - 1'b1;
          end
        end
        issue_pkg::FU_DONE: begin
          if (grant) begin
            state <= issue_pkg::FU_IDLE;  // Held until the CDB takes it
          end
        end
        default: state <= issue_pkg::FU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      result_tag     <= issue_entry.t_idx;
      result_rob_idx <= issue_entry.rob_idx;
      result_value   <= alu_value;
      op_a           <= rd_value1;
      op_b           <= rd_value2;
    end else if (mul_finish) begin
      result_value <= op_a * op_b;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module cdb_arbiter (
  input  wire logic [`NUM_FU-1:0]             done,
  input  wire logic [`NUM_FU-1:0][`TAG_W-1:0] result_tag,
  input  wire logic [`NUM_FU-1:0][`XLEN-1:0]  result_value,
  input  wire logic [`NUM_FU-1:0][`ROB_W-1:0] result_rob_idx,
  output logic [`NUM_FU-1:0]                  grant,
  output logic                                cdb_valid,
  output logic [`TAG_W-1:0]                   cdb_tag,
  output logic [`XLEN-1:0]                    cdb_value,
  output logic [`ROB_W-1:0]                   cdb_rob_idx
);

  // Scan from the top so the lowest done unit is the last to overwrite
  always_comb begin
    grant       = '0;
    cdb_valid   = 1'b0;
    cdb_tag     = '0;
    cdb_value   = '0;
    cdb_rob_idx = '0;
    for (int i = `NUM_FU - 1; i >= 0; i--) begin
      if (done[i]) begin
        grant       = '0;
        grant[i]    = 1'b1;
        cdb_valid   = 1'b1;
        cdb_tag     = result_tag[i];
        cdb_value   = result_value[i];
        cdb_rob_idx = result_rob_idx[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module phys_regfile (
  input  wire logic                             clock,
  input  wire logic                             reset,
  input  wire logic                             cdb_valid,
  input  wire logic [`TAG_W-1:0]                cdb_tag,
  input  wire logic [`XLEN-1:0]                 cdb_value,
  input  wire logic [`NUM_FU-1:0][`TAG_W-1:0]   rd_tag1,
  input  wire logic [`NUM_FU-1:0][`TAG_W-1:0]   rd_tag2,
  output logic [`NUM_FU-1:0][`XLEN-1:0]         rd_value1,
  output logic [`NUM_FU-1:0][`XLEN-1:0]         rd_value2
);

  logic [`XLEN-1:0] regs [`NUM_PREG];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PREG; i++) begin
        regs[i] <= '0;
      end
    end else if (cdb_valid) begin
      regs[cdb_tag] <= cdb_value;
    end
  end

  // Same-cycle CDB write wins over the stored value
  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      rd_value1[i] = (cdb_valid && rd_tag1[i] == cdb_tag) ? cdb_value : regs[rd_tag1[i]];
      rd_value2[i] = (cdb_valid && rd_tag2[i] == cdb_tag) ? cdb_value : regs[rd_tag2[i]];
    end
  end

endmodule

`default_nettype wire

//--- rtl/issue_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_core (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  dispatch_en,
  input  wire issue_pkg::fu_kind_t   dispatch_kind,
  input  wire issue_pkg::func_t      dispatch_func,
  input  wire logic [`ROB_W-1:0]     dispatch_rob_idx,
  input  wire logic [`TAG_W-1:0]     dispatch_t_idx,
  input  wire logic [`TAG_W-1:0]     dispatch_t1_idx,
  input  wire logic                  dispatch_t1_ready,
  input  wire logic [`TAG_W-1:0]     dispatch_t2_idx,
  input  wire logic                  dispatch_t2_ready,
  input  wire logic [`XLEN-1:0]      dispatch_imm,
  input  wire logic                  rollback_en,
  input  wire logic [`ROB_W-1:0]     rollback_idx,
  input  wire logic [`ROB_W-1:0]     rob_tail,
  output logic                       dispatch_ok,
  output logic                       cdb_valid,
  output logic [`TAG_W-1:0]          cdb_tag,
  output logic [`XLEN-1:0]           cdb_value,
  output logic [`ROB_W-1:0]          cdb_rob_idx
);

  localparam issue_pkg::fu_kind_t FU_KIND [`NUM_FU] = `FU_KIND_LIST;

  issue_pkg::rs_entry_t [`NUM_FU-1:0] issue_entry;
  logic [`NUM_FU-1:0]                 issue_valid;
  logic [`NUM_FU-1:0]                 fu_ready;
  logic [`NUM_FU-1:0]                 done;
  logic [`NUM_FU-1:0]                 grant;
  logic [`NUM_FU-1:0][`TAG_W-1:0]     rd_tag1;
  logic [`NUM_FU-1:0][`TAG_W-1:0]     rd_tag2;
  logic [`NUM_FU-1:0][`XLEN-1:0]      rd_value1;
  logic [`NUM_FU-1:0][`XLEN-1:0]      rd_value2;
  logic [`NUM_FU-1:0][`TAG_W-1:0]     result_tag;
  logic [`NUM_FU-1:0][`XLEN-1:0]      result_value;
  logic [`NUM_FU-1:0][`ROB_W-1:0]     result_rob_idx;

  rs u_rs (
    .clock             (clock),
    .reset             (reset),
    .dispatch_en       (dispatch_en),
    .dispatch_kind     (dispatch_kind),
    .dispatch_func     (dispatch_func),
    .dispatch_rob_idx  (dispatch_rob_idx),
    .dispatch_t_idx    (dispatch_t_idx),
    .dispatch_t1_idx   (dispatch_t1_idx),
    .dispatch_t1_ready (dispatch_t1_ready),
    .dispatch_t2_idx   (dispatch_t2_idx),
    .dispatch_t2_ready (dispatch_t2_ready),
    .dispatch_imm      (dispatch_imm),
    .rollback_en       (rollback_en),
    .rollback_idx      (rollback_idx),
    .rob_tail          (rob_tail),
    .cdb_valid         (cdb_valid),
    .cdb_tag           (cdb_tag),
    .fu_ready          (fu_ready),
    .dispatch_ok       (dispatch_ok),
    .issue_valid       (issue_valid),
    .issue_entry       (issue_entry)
  );

  for (genvar i = 0; i < `NUM_FU; i++) begin : g_fu
    assign rd_tag1[i] = issue_entry[i].t1_idx;  // Operands addressed by entry tags
    assign rd_tag2[i] = issue_entry[i].t2_idx;

    func_unit #(
      .KIND (FU_KIND[i])
    ) u_fu (
      .clock          (clock),
      .reset          (reset),
      .issue_valid    (issue_valid[i]),
      .issue_entry    (issue_entry[i]),
      .rd_value1      (rd_value1[i]),
      .rd_value2      (rd_value2[i]),
      .grant          (grant[i]),
      .fu_ready       (fu_ready[i]),
      .done           (done[i]),
      .result_tag     (result_tag[i]),
      .result_value   (result_value[i]),
      .result_rob_idx (result_rob_idx[i])
    );
  end

  cdb_arbiter u_arbiter (
    .done           (done),
    .result_tag     (result_tag),
    .result_value   (result_value),
    .result_rob_idx (result_rob_idx),
    .grant          (grant),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .cdb_value      (cdb_value),
    .cdb_rob_idx    (cdb_rob_idx)
  );

  phys_regfile u_regfile (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .rd_tag1   (rd_tag1),
    .rd_tag2   (rd_tag2),
    .rd_value1 (rd_value1),
    .rd_value2 (rd_value2)
  );

endmodule

`default_nettype wire

//--- verification/issue_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_core_asserts (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire logic                                cdb_valid,
  input  wire logic [`TAG_W-1:0]                   cdb_tag,
  input  wire logic                                dispatch_ok,
  input  wire issue_pkg::rs_entry_t [`NUM_FU-1:0]  issue_entry
);

  logic [`NUM_PREG-1:0] broadcast;  // Tags already seen on the CDB
  logic                 all_free;
  int                   fail_count = 0;

  always_comb begin
    all_free = 1'b1;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (issue_entry[i].busy) begin
        all_free = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      broadcast <= '0;
    end else if (cdb_valid) begin
      broadcast[cdb_tag] <= 1'b1;
    end
  end

  cdb_quiet_after_reset: assert property (@(posedge clock) reset |=> !cdb_valid)
    else begin
      fail_count++;
      $error("cdb_valid is high in the cycle after reset");
    end

  // Tags are never reused by the stimulus
  tag_broadcast_once: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> !broadcast[cdb_tag])
    else begin
      fail_count++;
      $error("tag %0d appeared on the CDB a second time", cdb_tag);
    end

  free_station_accepts: assert property (@(posedge clock) disable iff (reset)
    all_free |-> dispatch_ok)
    else begin
      fail_count++;
      $error("dispatch_ok is low although every entry is free");
    end

  cdb_tag_known: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> !$isunknown(cdb_tag))
    else begin
      fail_count++;
      $error("cdb_tag holds unknown bits during a broadcast");
    end

endmodule

bind issue_core issue_core_asserts u_asserts (
  .clock       (clock),
  .reset       (reset),
  .cdb_valid   (cdb_valid),
  .cdb_tag     (cdb_tag),
  .dispatch_ok (dispatch_ok),
  .issue_entry (issue_entry)
);

`default_nettype wire

//--- verification/issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_core_tb;

  localparam int WAIT_LIMIT   = 100;  // Cycles allowed in each wait loop
  localparam int NEVER_CYCLES = 40;   // Watch window for squashed tags

  typedef struct packed {
    logic                 rollback;   // Rollback action instead of a dispatch
    logic                 never;      // Tag must never reach the CDB
    issue_pkg::fu_kind_t  kind;
    issue_pkg::func_t     func;
    logic [`ROB_W-1:0]    rob_idx;    // Rollback index on rollback rows
    logic [`ROB_W-1:0]    rob_tail;
    logic [`TAG_W-1:0]    t_idx;
    logic [`TAG_W-1:0]    t1_idx;
    logic                 t1_ready;
    logic [`TAG_W-1:0]    t2_idx;
    logic                 t2_ready;
    logic [`XLEN-1:0]     imm;
  } row_t;

  logic                 clock;
  logic                 reset;
  logic                 dispatch_en;
  issue_pkg::fu_kind_t  dispatch_kind;
  issue_pkg::func_t     dispatch_func;
  logic [`ROB_W-1:0]    dispatch_rob_idx;
  logic [`TAG_W-1:0]    dispatch_t_idx;
  logic [`TAG_W-1:0]    dispatch_t1_idx;
  logic                 dispatch_t1_ready;
  logic [`TAG_W-1:0]    dispatch_t2_idx;
  logic                 dispatch_t2_ready;
  logic [`XLEN-1:0]     dispatch_imm;
  logic                 rollback_en;
  logic [`ROB_W-1:0]    rollback_idx;
  logic [`ROB_W-1:0]    rob_tail;
  logic                 dispatch_ok;
  logic                 cdb_valid;
  logic [`TAG_W-1:0]    cdb_tag;
  logic [`XLEN-1:0]     cdb_value;
  logic [`ROB_W-1:0]    cdb_rob_idx;

  row_t              rows[$];
  string             row_name[$];
  logic [`XLEN-1:0]  row_expect[$];
  logic [`XLEN-1:0]  model_value [`NUM_PREG];  // Reference register values
  bit                produced [`NUM_PREG];     // Tag has a dispatched producer
  bit                seen [`NUM_PREG];
  int                seen_count [`NUM_PREG];
  logic [`XLEN-1:0]  seen_value [`NUM_PREG];
  logic [`ROB_W-1:0] seen_rob [`NUM_PREG];

  issue_core u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // CDB record, taken mid-cycle
  always @(negedge clock) begin
    if (!reset && cdb_valid) begin
      seen[cdb_tag]       = 1'b1;
      seen_count[cdb_tag] = seen_count[cdb_tag] + 1;
      seen_value[cdb_tag] = cdb_value;
      seen_rob[cdb_tag]   = cdb_rob_idx;
    end
  end

  function automatic logic [`XLEN-1:0] expected_result(input issue_pkg::func_t func,
      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] imm);
    case (func)
      issue_pkg::OP_ADD: return a + b;
      issue_pkg::OP_SUB: return a - b;
      issue_pkg::OP_AND: return a & b;
      issue_pkg::OP_XOR: return a ^ b;
      issue_pkg::OP_MUL: return a * b;   // Low half of the product
      issue_pkg::OP_LI:  return imm;
      default:           return '0;
    endcase
  endfunction

  task automatic abort_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic add_row(input string name, input issue_pkg::fu_kind_t kind,
      input issue_pkg::func_t func, input int rob, input int t, input int t1, input int r1,
      input int t2, input int r2, input int imm, input int never);
    row_t r;
    r          = '0;
    r.never    = (never != 0);
    r.kind     = kind;
    r.func     = func;
    r.rob_idx  = rob[`ROB_W-1:0];
    r.t_idx    = t[`TAG_W-1:0];
    r.t1_idx   = t1[`TAG_W-1:0];
    r.t1_ready = (r1 != 0);
    r.t2_idx   = t2[`TAG_W-1:0];
    r.t2_ready = (r2 != 0);
    r.imm      = imm;
    rows.push_back(r);
    row_name.push_back(name);
    if (r.never) begin
      row_expect.push_back('0);
    end else begin
      row_expect.push_back(expected_result(func, model_value[r.t1_idx],
                                           model_value[r.t2_idx], r.imm));
      model_value[r.t_idx] = row_expect[$];
    end
  endtask

  task automatic add_rollback(input string name, input int idx, input int tail);
    row_t r;
    r          = '0;
    r.rollback = 1'b1;
    r.rob_idx  = idx[`ROB_W-1:0];
    r.rob_tail = tail[`ROB_W-1:0];
    rows.push_back(r);
    row_name.push_back(name);
    row_expect.push_back('0);
  endtask

  task automatic wait_tag(input logic [`TAG_W-1:0] tag);
    int cycles;
    cycles = 0;
    while (!seen[tag]) begin
      @(posedge clock);
      cycles++;
      assert (cycles < WAIT_LIMIT)
        else abort_with_failure($sformatf("Timed out waiting for tag %0d on the CDB", tag));
    end
  endtask

  task automatic dispatch_row(input int k);
    row_t r;
    int   tries;
    logic accepted;
    r = rows[k];
    if (r.t1_ready && produced[r.t1_idx]) wait_tag(r.t1_idx);  // Value must be in the file
    if (r.t2_ready && produced[r.t2_idx]) wait_tag(r.t2_idx);
    @(negedge clock);
    dispatch_en       = 1'b1;
    dispatch_kind     = r.kind;
    dispatch_func     = r.func;
    dispatch_rob_idx  = r.rob_idx;
    dispatch_t_idx    = r.t_idx;
    dispatch_t1_idx   = r.t1_idx;
    dispatch_t1_ready = r.t1_ready;
    dispatch_t2_idx   = r.t2_idx;
    dispatch_t2_ready = r.t2_ready;
    dispatch_imm      = r.imm;
    tries    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      #1;
      accepted = dispatch_ok;  // Stable until the next rising edge
      @(posedge clock);
      if (!accepted) begin
        tries++;
        assert (tries < WAIT_LIMIT)
          else abort_with_failure($sformatf("Row %s was never accepted", row_name[k]));
        @(negedge clock);
      end
    end
    if (!r.never) produced[r.t_idx] = 1'b1;
    @(negedge clock);
    dispatch_en = 1'b0;
    @(posedge clock);
  endtask

  task automatic apply_rollback(input int k);
    @(negedge clock);
    rollback_en  = 1'b1;
    rollback_idx = rows[k].rob_idx;
    rob_tail     = rows[k].rob_tail;
    @(negedge clock);
    rollback_en = 1'b0;
    @(posedge clock);
  endtask

  task automatic check_row(input int k);
    row_t r;
    r = rows[k];
    if (r.never) begin
      for (int c = 0; c < NEVER_CYCLES; c++) begin
        assert (!seen[r.t_idx]) else abort_with_failure($sformatf(
          "Squashed row %s put tag %0d on the CDB", row_name[k], r.t_idx));
        @(posedge clock);
      end
    end else begin
      wait_tag(r.t_idx);
      assert (seen_value[r.t_idx] == row_expect[k]) else abort_with_failure($sformatf(
        "[ERROR] %s: expected %h, actual %h", row_name[k], row_expect[k], seen_value[r.t_idx]));
      assert (seen_rob[r.t_idx] == r.rob_idx) else abort_with_failure($sformatf(
        "[ERROR] %s rob_idx: expected %0d, actual %0d", row_name[k], r.rob_idx,
        seen_rob[r.t_idx]));
      assert (seen_count[r.t_idx] == 1) else abort_with_failure($sformatf(
        "[ERROR] %s broadcast count: expected 1, actual %0d", row_name[k],
        seen_count[r.t_idx]));
    end
  endtask

  initial begin
    reset             = 1'b1;
    dispatch_en       = 1'b0;
    dispatch_kind     = issue_pkg::FU_ALU;
    dispatch_func     = issue_pkg::OP_ADD;
    dispatch_rob_idx  = '0;
    dispatch_t_idx    = '0;
    dispatch_t1_idx   = '0;
    dispatch_t1_ready = 1'b0;
    dispatch_t2_idx   = '0;
    dispatch_t2_ready = 1'b0;
    dispatch_imm      = '0;
    rollback_en       = 1'b0;
    rollback_idx      = '0;
    rob_tail          = '0;
    foreach (model_value[i]) model_value[i] = '0;

    // name, kind, func, rob, tag, src1, rdy1, src2, rdy2, imm, squashed
    add_row("li_a", issue_pkg::FU_ALU, issue_pkg::OP_LI, 0, 1, 0, 1, 0, 1, 32'h0000_1234, 0);
    add_row("li_b", issue_pkg::FU_ALU, issue_pkg::OP_LI, 1, 2, 0, 1, 0, 1, 32'hf0f0_0f0f, 0);
    add_row("add", issue_pkg::FU_ALU, issue_pkg::OP_ADD, 2, 3, 1, 1, 2, 1, 0, 0);
    add_row("sub", issue_pkg::FU_ALU, issue_pkg::OP_SUB, 3, 4, 1, 1, 2, 1, 0, 0);
    add_row("and", issue_pkg::FU_ALU, issue_pkg::OP_AND, 4, 5, 3, 1, 2, 1, 0, 0);
    add_row("xor", issue_pkg::FU_ALU, issue_pkg::OP_XOR, 5, 6, 4, 1, 1, 1, 0, 0);
    add_row("mul_a", issue_pkg::FU_MUL, issue_pkg::OP_MUL, 6, 7, 3, 1, 2, 1, 0, 0);
    add_row("wake_add", issue_pkg::FU_ALU, issue_pkg::OP_ADD, 7, 8, 7, 0, 1, 1, 0, 0);
    add_row("alu_p", issue_pkg::FU_ALU, issue_pkg::OP_XOR, 8, 9, 5, 1, 6, 1, 0, 0);
    add_row("alu_q", issue_pkg::FU_ALU, issue_pkg::OP_ADD, 9, 10, 6, 1, 5, 1, 0, 0);
    add_row("mul_b", issue_pkg::FU_MUL, issue_pkg::OP_MUL, 10, 11, 4, 1, 6, 1, 0, 0);
    add_row("mul_c", issue_pkg::FU_MUL, issue_pkg::OP_MUL, 11, 12, 9, 1, 1, 1, 0, 0);
    add_row("mul_d", issue_pkg::FU_MUL, issue_pkg::OP_MUL, 15, 13, 5, 1, 3, 1, 0, 0);
    add_row("sq_a", issue_pkg::FU_ALU, issue_pkg::OP_ADD, 12, 14, 13, 0, 1, 1, 0, 1);
    add_row("sq_b", issue_pkg::FU_ALU, issue_pkg::OP_SUB, 13, 15, 13, 0, 2, 1, 0, 1);
    add_rollback("rollback", 12, 14);
    add_row("after", issue_pkg::FU_ALU, issue_pkg::OP_AND, 12, 16, 12, 1, 13, 1, 0, 0);

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    assert (cdb_valid == 1'b0) else abort_with_failure($sformatf(
      "[ERROR] reset_cdb: expected 0, actual %0d", cdb_valid));
    @(posedge clock);

    foreach (rows[k]) begin
      if (rows[k].rollback) begin
        apply_rollback(k);
      end else begin
        dispatch_row(k);
      end
    end
    foreach (rows[k]) begin
      if (!rows[k].rollback) check_row(k);
    end

    if (u_dut.u_asserts.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_with_failure("A bound assertion on issue_core failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/issue_pkg.sv
rs/rs.sv
rtl/func_unit.sv
rtl/cdb_arbiter.sv
rtl/phys_regfile.sv
rtl/issue_core.sv
verification/issue_core_asserts.sv
verification/issue_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the issue_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module issue_core_tb \
  -f sources.f -o issue_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/issue_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== PASS ===" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
